// File: common/board_macros.svh
/*
 * Board timing constants: reset hold, switch debounce window,
 * addressable LED bit timing and LED chain length
 */

`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// Core reset hold after both reset sources release
`define RST_HOLD_CYCLES 16

// Stable cycles before a debounced switch group changes
`define DEBOUNCE_CYCLES 4

// LED bit period and high times for a 0 and a 1
`define WS_BIT_CYCLES 10
`define WS_T0H_CYCLES 3
`define WS_T1H_CYCLES 7

// Low gap that latches a frame into the chain
`define WS_LATCH_CYCLES 50

`define WS_PIXELS 2

`endif

// File: common/board_pkg.sv
/*
 * Board side types: navigation and user switch groups,
 * protection mode and the switch that selects it
 */

package board_pkg;

  // Joystick style navigation switches
  typedef logic [4:0] nav_sw_t;

  // User DIP switches, also mirrored onto the user LEDs
  typedef logic [7:0] usr_sw_t;

  // Memory protection mode shown on the cheri and legacy LEDs
  typedef enum logic {
    PROT_CHERI  = 1'b0,
    PROT_LEGACY = 1'b1
  } prot_mode_e;

  // User switch sampled once after reset for the mode
  localparam int USR_SW_MODE_BIT = 7;

endpackage

// File: common/ws281x_pkg.sv
/*
 * Addressable LED chain types: pixel colour in wire order,
 * colour table for the navigation switches and bits per pixel
 */

package ws281x_pkg;

  localparam int RGB_BITS = 24;

  // Field order is the order on the wire, msb first
  typedef struct packed {
    logic [7:0] g;
    logic [7:0] r;
    logic [7:0] b;
  } rgb_t;

  localparam rgb_t COLOUR_OFF = '{g: 8'h00, r: 8'h00, b: 8'h00};

  // One entry per navigation switch, index 0 first
  localparam rgb_t COLOUR_TABLE [5] = '{
    '{g: 8'h00, r: 8'h40, b: 8'h00},
    '{g: 8'h40, r: 8'h00, b: 8'h00},
    '{g: 8'h00, r: 8'h00, b: 8'h40},
    '{g: 8'h20, r: 8'h20, b: 8'h00},
    '{g: 8'h10, r: 8'h10, b: 8'h10}
  };

endpackage

// File: hdl/board_rst_ctrl.sv
/*
 * Core reset controller: button synchroniser and hold counter
 */

`timescale 1ns/1ps
`include "board_macros.svh"

module board_rst_ctrl (
  input  logic clk_sys,
  input  logic rst_sys_n,
  input  logic rst_btn_n_i,
  output logic rst_core_n_o
);

  localparam int HoldW = $clog2(`RST_HOLD_CYCLES + 1);

  logic [1:0]       btn_sync_q;
  logic [HoldW-1:0] hold_cnt_q;
  logic             release_q;

  // Button is active low, so the sync chain idles at one
  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      btn_sync_q <= 2'b11;
    end else begin
      btn_sync_q <= {btn_sync_q[0], rst_btn_n_i};
    end
  end

  // Counter restarts for as long as the button is held
  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      hold_cnt_q <= '0;
      release_q  <= 1'b0;
    end else if (!btn_sync_q[1]) begin
      hold_cnt_q <= '0;
      release_q  <= 1'b0;
    end else if (hold_cnt_q != HoldW'(`RST_HOLD_CYCLES)) begin
      hold_cnt_q <= hold_cnt_q + 1'b1;
    end else begin
      release_q <= 1'b1;
    end
  end

  // Pressed button pulls the core into reset without waiting a cycle
  assign rst_core_n_o = release_q & btn_sync_q[1];

endmodule

// File: hdl/switch_debounce.sv
/*
 * Switch group synchroniser, debouncer and polarity inverter,
 * shared by every switch group through a type parameter
 */

`timescale 1ns/1ps
`include "board_macros.svh"

module switch_debounce #(
  parameter type sw_t = logic [7:0]
) (
  input  logic clk_sys,
  input  logic rst_sys_n,
  input  sw_t  sw_n_i,
  output sw_t  sw_o,
  output logic settled_o
);

  localparam int CntW = $clog2(`DEBOUNCE_CYCLES + 1);

  sw_t             sync1_q;
  sw_t             sync2_q;
  sw_t             cand_q;
  logic [CntW-1:0] stable_cnt_q;
  sw_t             sw_q;
  logic            settled_q;

  // Whole group is synchronised together so a diagonal press stays coherent
  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      sync1_q <= '1;
      sync2_q <= '1;
    end else begin
      sync1_q <= sw_n_i;
      sync2_q <= sync1_q;
    end
  end

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      cand_q       <= '1;
      stable_cnt_q <= '0;
      sw_q         <= '0;
      settled_q    <= 1'b0;
    end else if (sync2_q != cand_q) begin
      // Any change restarts the window
      cand_q       <= sync2_q;
      stable_cnt_q <= '0;
    end else if (stable_cnt_q != CntW'(`DEBOUNCE_CYCLES - 1)) begin
      stable_cnt_q <= stable_cnt_q + 1'b1;
    end else begin
      sw_q      <= sw_t'(~cand_q);
      settled_q <= 1'b1;
    end
  end

  assign sw_o      = sw_q;
  assign settled_o = settled_q;

endmodule

// File: hdl/board_status.sv
/*
 * Board status: protection mode latch, user and mode LEDs,
 * LED chain colour picked from the navigation switches
 */

`timescale 1ns/1ps

module board_status (
  input  logic               clk_sys,
  input  logic               rst_sys_n,
  input  board_pkg::nav_sw_t nav_sw_i,
  input  board_pkg::usr_sw_t usr_sw_i,
  input  logic               usr_settled_i,
  output board_pkg::usr_sw_t usr_led_o,
  output logic               led_cheri_o,
  output logic               led_legacy_o,
  output ws281x_pkg::rgb_t   colour_o
);

  import board_pkg::*;
  import ws281x_pkg::*;

  logic       mode_decided_q;
  prot_mode_e mode_q;
  rgb_t       colour_d;
  rgb_t       colour_q;

  // Mode is taken from the first settled switch value and then held
  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      mode_decided_q <= 1'b0;
      mode_q         <= PROT_CHERI;
    end else if (usr_settled_i && !mode_decided_q) begin
      mode_decided_q <= 1'b1;
      mode_q         <= usr_sw_i[USR_SW_MODE_BIT] ? PROT_LEGACY : PROT_CHERI;
    end
  end

  assign led_cheri_o  = (mode_q == PROT_CHERI);
  assign led_legacy_o = (mode_q == PROT_LEGACY);
  assign usr_led_o    = usr_sw_i;

  // Walk down from the top so the lowest pressed switch wins
  always_comb begin
    colour_d = COLOUR_OFF;
    for (int i = $bits(nav_sw_t) - 1; i >= 0; i--) begin
      if (nav_sw_i[i]) colour_d = COLOUR_TABLE[i];
    end
  end

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      colour_q <= COLOUR_OFF;
    end else begin
      colour_q <= colour_d;
    end
  end

  assign colour_o = colour_q;

endmodule

// File: ws281x/ws281x_frame_seq.sv
/*
 * LED chain frame sequencer: one colour for every pixel,
 * a new frame each time the driver returns to idle
 */

`timescale 1ns/1ps
`include "board_macros.svh"

module ws281x_frame_seq (
  input  logic             clk_sys,
  input  logic             rst_sys_n,
  input  ws281x_pkg::rgb_t colour_i,
  input  logic             drv_idle_i,
  output ws281x_pkg::rgb_t pix_o,
  output logic             pix_valid_o,
  output logic             pix_last_o,
  input  logic             pix_ack_i
);

  import ws281x_pkg::*;

  localparam int CntW = $clog2(`WS_PIXELS + 1);

  rgb_t            pix_q;
  logic            valid_q;
  logic [CntW-1:0] pix_cnt_q;
  logic            at_last;

  assign at_last = (pix_cnt_q == CntW'(`WS_PIXELS - 1));

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      valid_q   <= 1'b0;
      pix_cnt_q <= '0;
    end else if (!valid_q) begin
      // Next frame starts once the latch gap of the last one is over
      if (drv_idle_i) begin
        valid_q   <= 1'b1;
        pix_cnt_q <= '0;
      end
    end else if (pix_ack_i) begin
      if (at_last) valid_q <= 1'b0;
      else         pix_cnt_q <= pix_cnt_q + 1'b1;
    end
  end

  // Colour is held for the whole frame
  always_ff @(posedge clk_sys) begin
    if (!valid_q && drv_idle_i) pix_q <= colour_i;
  end

  assign pix_o       = pix_q;
  assign pix_valid_o = valid_q;
  assign pix_last_o  = valid_q & at_last;

endmodule

// File: ws281x/ws281x_drv.sv
/*
 * Single wire LED driver: serialises pixels msb first as
 * pulse width coded bits and ends each frame with a low latch gap
 */

`timescale 1ns/1ps
`include "board_macros.svh"

module ws281x_drv (
  input  logic             clk_sys,
  input  logic             rst_sys_n,
  input  ws281x_pkg::rgb_t data_i,
  input  logic             data_valid_i,
  input  logic             data_last_i,
  output logic             data_ack_o,
  output logic             idle_o,
  output logic             dout_o
);

  import ws281x_pkg::*;

  localparam int CycMax = (`WS_LATCH_CYCLES > `WS_BIT_CYCLES) ?
                          `WS_LATCH_CYCLES : `WS_BIT_CYCLES;
  localparam int CycW   = $clog2(CycMax + 1);
  localparam int BitW   = $clog2(RGB_BITS);

  typedef enum logic [1:0] {
    DRV_IDLE,
    DRV_SEND,
    DRV_LATCH
  } drv_state_e;

  drv_state_e          state_q;
  logic [CycW-1:0]     cyc_q;
  logic [BitW-1:0]     bit_idx_q;
  logic [RGB_BITS-1:0] shift_q;
  logic                last_q;
  logic                bit_end;
  logic                pix_end;
  logic                take;
  logic [CycW-1:0]     high_cycles;

  assign bit_end = (cyc_q == CycW'(`WS_BIT_CYCLES - 1));
  assign pix_end = bit_end && (bit_idx_q == BitW'(RGB_BITS - 1));

  // Pixel is taken from idle, or back to back at the end of a non-last pixel
  assign take = data_valid_i &&
                ((state_q == DRV_IDLE) || ((state_q == DRV_SEND) && pix_end && !last_q));

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      state_q   <= DRV_IDLE;
      cyc_q     <= '0;
      bit_idx_q <= '0;
      last_q    <= 1'b0;
    end else if (take) begin
      state_q   <= DRV_SEND;
      cyc_q     <= '0;
      bit_idx_q <= '0;
      last_q    <= data_last_i;
    end else begin
      case (state_q)
        DRV_SEND: begin
          if (pix_end) begin
            // Last pixel done, or the sequencer ran dry
            state_q <= DRV_LATCH;
            cyc_q   <= '0;
          end else if (bit_end) begin
            cyc_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
          end else begin
            cyc_q <= cyc_q + 1'b1;
          end
        end
        DRV_LATCH: begin
          if (cyc_q == CycW'(`WS_LATCH_CYCLES - 1)) begin
            state_q <= DRV_IDLE;
            cyc_q   <= '0;
          end else begin
            cyc_q <= cyc_q + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (take) begin
      shift_q <= data_i;
    end else if ((state_q == DRV_SEND) && bit_end) begin
      shift_q <= {shift_q[RGB_BITS-2:0], 1'b0};
    end
  end

  assign high_cycles = shift_q[RGB_BITS-1] ? CycW'(`WS_T1H_CYCLES) : CycW'(`WS_T0H_CYCLES);

  // High part sits at the start of each bit period
  assign dout_o     = (state_q == DRV_SEND) && (cyc_q < high_cycles);
  assign data_ack_o = take;
  assign idle_o     = (state_q == DRV_IDLE);

endmodule

// File: hdl/sonata_board_top.sv
/*
 * Board shell top level: reset controller, switch debouncers,
 * status and mode logic, and the addressable LED chain
 */

`timescale 1ns/1ps

module sonata_board_top (
  input  logic                clk_sys,
  input  logic                rst_sys_n,
  input  logic                rst_btn_n_i,
  input  board_pkg::nav_sw_t  nav_sw_n_i,
  input  board_pkg::usr_sw_t  usr_sw_n_i,
  output board_pkg::usr_sw_t  usr_led_o,
  output logic                led_bootok_o,
  output logic                led_cheri_o,
  output logic                led_legacy_o,
  output logic                rgbled_o
);

  import board_pkg::*;
  import ws281x_pkg::*;

  logic    rst_core_n;
  nav_sw_t nav_sw;
  usr_sw_t usr_sw;
  logic    usr_settled;
  rgb_t    colour;
  rgb_t    pix;
  logic    pix_valid;
  logic    pix_last;
  logic    pix_ack;
  logic    drv_idle;
  logic    drv_dout;

  board_rst_ctrl board_rst_ctrl_inst (
    .clk_sys      (clk_sys),
    .rst_sys_n    (rst_sys_n),
    .rst_btn_n_i  (rst_btn_n_i),
    .rst_core_n_o (rst_core_n)
  );

  // Boot ok lights once the core leaves reset
  assign led_bootok_o = rst_core_n;

  switch_debounce #(
    .sw_t (nav_sw_t)
  ) nav_debounce_inst (
    .clk_sys   (clk_sys),
    .rst_sys_n (rst_core_n),
    .sw_n_i    (nav_sw_n_i),
    .sw_o      (nav_sw),
    .settled_o ()
  );

  switch_debounce #(
    .sw_t (usr_sw_t)
  ) usr_debounce_inst (
    .clk_sys   (clk_sys),
    .rst_sys_n (rst_core_n),
    .sw_n_i    (usr_sw_n_i),
    .sw_o      (usr_sw),
    .settled_o (usr_settled)
  );

  board_status board_status_inst (
    .clk_sys       (clk_sys),
    .rst_sys_n     (rst_core_n),
    .nav_sw_i      (nav_sw),
    .usr_sw_i      (usr_sw),
    .usr_settled_i (usr_settled),
    .usr_led_o     (usr_led_o),
    .led_cheri_o   (led_cheri_o),
    .led_legacy_o  (led_legacy_o),
    .colour_o      (colour)
  );

  ws281x_frame_seq ws281x_frame_seq_inst (
    .clk_sys     (clk_sys),
    .rst_sys_n   (rst_core_n),
    .colour_i    (colour),
    .drv_idle_i  (drv_idle),
    .pix_o       (pix),
    .pix_valid_o (pix_valid),
    .pix_last_o  (pix_last),
    .pix_ack_i   (pix_ack)
  );

  ws281x_drv ws281x_drv_inst (
    .clk_sys      (clk_sys),
    .rst_sys_n    (rst_core_n),
    .data_i       (pix),
    .data_valid_i (pix_valid),
    .data_last_i  (pix_last),
    .data_ack_o   (pix_ack),
    .idle_o       (drv_idle),
    .dout_o       (drv_dout)
  );

  // Level shifter on the board inverts the LED data line
  assign rgbled_o = ~drv_dout;

endmodule

// File: tests/tb_sonata_board_top.sv
/*
 * Testbench for the board shell: applies switch rows from the stimulus file,
 * checks reset, user and mode LEDs, and decodes the LED chain line
 */

`timescale 1ns/1ps
`include "board_macros.svh"

module tb_sonata_board_top;

  import board_pkg::*;
  import ws281x_pkg::*;

  localparam int ClkPeriod   = 100;
  localparam int NumRows     = 14;
  localparam int SettleWait  = `DEBOUNCE_CYCLES + 4;
  localparam int GlitchLen   = `DEBOUNCE_CYCLES - 2;
  localparam int BitLowMax   = `WS_BIT_CYCLES - `WS_T0H_CYCLES;
  localparam int PixelBits   = 24;
  localparam int FrameCycles = `WS_PIXELS * PixelBits * `WS_BIT_CYCLES + `WS_LATCH_CYCLES + 4;
  localparam int RowCycles   = 3 * FrameCycles + 4 * SettleWait + 2 * `RST_HOLD_CYCLES + 16;
  localparam int TimeoutCyc  = NumRows * RowCycles + 200;

  logic    clk_sys = 1'b0;
  logic    rst_sys_n;
  logic    rst_btn_n_i;
  nav_sw_t nav_sw_n_i;
  usr_sw_t usr_sw_n_i;
  usr_sw_t usr_led_o;
  logic    led_bootok_o;
  logic    led_cheri_o;
  logic    led_legacy_o;
  logic    rgbled_o;

  logic [51:0] stim_rows [NumRows];
  int          errors = 0;
  int          checks = 0;
  prot_mode_e  expected_mode;

  // Decoder state
  int          high_cnt = 0;
  int          low_cnt = 0;
  int          bit_cnt = 0;
  int          pix_cnt = 0;
  int          frame_count = 0;
  logic [23:0] pix_shift;
  logic [23:0] frame_colour;
  logic [23:0] last_colour;

  sonata_board_top sonata_board_top_inst (
    .clk_sys      (clk_sys),
    .rst_sys_n    (rst_sys_n),
    .rst_btn_n_i  (rst_btn_n_i),
    .nav_sw_n_i   (nav_sw_n_i),
    .usr_sw_n_i   (usr_sw_n_i),
    .usr_led_o    (usr_led_o),
    .led_bootok_o (led_bootok_o),
    .led_cheri_o  (led_cheri_o),
    .led_legacy_o (led_legacy_o),
    .rgbled_o     (rgbled_o)
  );

  always #(ClkPeriod / 2) clk_sys = ~clk_sys;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // Inputs change 5 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_sys);
    #5;
  endtask

  task automatic measure_reset_hold();
    int n;
    for (n = 0; n < `RST_HOLD_CYCLES; n++) begin
      compare_value("led_bootok_o", 0, led_bootok_o);
      wait_cycles(1);
    end
    n = 0;
    while (!led_bootok_o && n < `RST_HOLD_CYCLES + 8) begin
      wait_cycles(1);
      n++;
    end
    if (!led_bootok_o) begin
      errors++;
      $display("Boot ok LED did not come back on after the reset hold at %0t ns", $time);
    end
  endtask

  task automatic press_button();
    rst_btn_n_i = 1'b0;
    // Two synchroniser flops stand between the pin and the core reset
    wait_cycles(3);
    compare_value("led_bootok_o", 0, led_bootok_o);
    wait_cycles(2);
    rst_btn_n_i = 1'b1;
    measure_reset_hold();
  endtask

  task automatic apply_glitch(input usr_sw_t usr_n, input usr_sw_t exp_led);
    usr_sw_n_i = ~usr_n;
    wait_cycles(GlitchLen);
    usr_sw_n_i = usr_n;
    // LEDs hold through the glitch and the window after it
    repeat (SettleWait) begin
      wait_cycles(1);
      compare_value("usr_led_o", exp_led, usr_led_o);
    end
  endtask

  task automatic run_row(input int idx);
    logic [51:0] row;
    nav_sw_t     nav_n;
    usr_sw_t     usr_n;
    logic        btn_n;
    usr_sw_t     exp_led;
    rgb_t        exp_colour;
    int          start;
    row        = stim_rows[idx];
    nav_n      = row[48:44];
    usr_n      = row[43:36];
    btn_n      = row[32];
    exp_led    = row[31:24];
    exp_colour = row[23:0];
    nav_sw_n_i = nav_n;
    usr_sw_n_i = usr_n;
    if (!btn_n) begin
      press_button();
      // Fresh core reset, so the mode follows switch 7 again
      expected_mode = usr_n[USR_SW_MODE_BIT] ? PROT_CHERI : PROT_LEGACY;
    end
    wait_cycles(SettleWait);
    compare_value("usr_led_o", exp_led, usr_led_o);
    compare_value("led_cheri_o", expected_mode == PROT_CHERI, led_cheri_o);
    compare_value("led_legacy_o", expected_mode == PROT_LEGACY, led_legacy_o);
    start = frame_count;
    while (frame_count < start + 2) begin
      wait_cycles(1);
    end
    compare_value("rgbled_o colour", exp_colour, last_colour);
    apply_glitch(usr_n, exp_led);
  endtask

  // Pulse decoder on the inverted LED line, sampled mid cycle
  always @(negedge clk_sys) begin
    if (!led_bootok_o) begin
      high_cnt = 0;
      low_cnt  = 0;
      bit_cnt  = 0;
      pix_cnt  = 0;
    end else if (!rgbled_o) begin
      if (high_cnt == 0 && low_cnt > BitLowMax && low_cnt < `WS_LATCH_CYCLES) begin
        errors++;
        $display("LED line low for %0d cycles at %0t ns, neither a bit nor a latch gap",
                 low_cnt, $time);
      end
      high_cnt++;
      low_cnt = 0;
    end else begin
      if (high_cnt != 0) begin
        if (high_cnt != `WS_T1H_CYCLES && high_cnt != `WS_T0H_CYCLES) begin
          errors++;
          $display("LED pulse of %0d cycles at %0t ns is not a valid bit", high_cnt, $time);
        end
        pix_shift = {pix_shift[22:0], high_cnt == `WS_T1H_CYCLES};
        bit_cnt++;
        if (bit_cnt == PixelBits) begin
          if (pix_cnt == 0) frame_colour = pix_shift;
          else compare_value("rgbled_o pixel in frame", frame_colour, pix_shift);
          pix_cnt++;
          bit_cnt = 0;
        end
      end
      high_cnt = 0;
      low_cnt++;
      if (low_cnt == `WS_LATCH_CYCLES) begin
        compare_value("rgbled_o pixels per frame", `WS_PIXELS, pix_cnt);
        compare_value("rgbled_o stray bits", 0, bit_cnt);
        last_colour = frame_colour;
        frame_count++;
        pix_cnt = 0;
        bit_cnt = 0;
      end
    end
  end

  initial begin
    #(TimeoutCyc * ClkPeriod);
    $display("Timeout after %0d cycles, the test did not reach its end", TimeoutCyc);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst_sys_n     = 1'b0;
    rst_btn_n_i   = 1'b1;
    nav_sw_n_i    = '1;
    usr_sw_n_i    = '1;
    expected_mode = PROT_CHERI;
    $readmemh("tests/board_stimulus.txt", stim_rows);
    if ($isunknown(stim_rows[NumRows-1])) begin
      errors++;
      $display("Stimulus file holds fewer rows than the test expects");
    end
    repeat (5) @(posedge clk_sys);
    #5;
    compare_value("rgbled_o", 1, rgbled_o);
    compare_value("usr_led_o", 0, usr_led_o);
    compare_value("led_bootok_o", 0, led_bootok_o);
    compare_value("led_cheri_o", 1, led_cheri_o);
    compare_value("led_legacy_o", 0, led_legacy_o);
    rst_sys_n = 1'b1;
    measure_reset_hold();
    wait_cycles(SettleWait);
    compare_value("led_cheri_o", 1, led_cheri_o);
    for (int i = 0; i < NumRows; i++) begin
      run_row(i);
    end
    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tests/board_stimulus.txt
// Columns: nav_sw_n _ usr_sw_n _ button_n _ expected usr_led _ expected pixel (g r b)
// Switches are active low; button_n 0 presses the reset button with the row's switches set
1f_ff_1_00_000000
1e_fe_1_01_004000
1d_fd_1_02_400000
1b_7f_1_80_000040
17_5a_1_a5_202000
0f_3c_1_c3_101010
12_ff_1_00_004000
0d_00_1_ff_400000
19_7e_0_81_400000
1f_ff_1_00_000000
13_f0_1_0f_000040
1e_e7_0_18_004000
07_7f_1_80_202000
1f_ff_1_00_000000

// File: files.f
+incdir+common
common/board_pkg.sv
common/ws281x_pkg.sv
hdl/board_rst_ctrl.sv
hdl/switch_debounce.sv
hdl/board_status.sv
ws281x/ws281x_frame_seq.sv
ws281x/ws281x_drv.sv
hdl/sonata_board_top.sv
tests/tb_sonata_board_top.sv
